/* Makefile */
# Verilator build and run for the uart testbench

VERILATOR ?= verilator
TOP       ?= tb_uart
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FLIST     ?= tb.f

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) --binary --timing --assert -Wall -f $(FLIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Verification passed" $(LOG)

check:
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/uart_defs.svh */
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// register bus address width
`define UART_ADDR_W       3
// data byte width
`define UART_DATA_W       8

// tx fifo depth and a counter width that holds the full count
`define UART_FIFO_DEPTH   16
`define UART_FIFO_CNT_W   5

// divisor latch width
`define UART_DL_W         16
// baud enables per serial bit
`define UART_OVERSAMPLE   16

`define UART_LCR_RESET    8'h03
`define UART_LSR_RESET    8'h60
`define UART_IIR_RESET    4'h1

`define UART_LC_STB       2
`define UART_LC_PEN       3
`define UART_LC_EPS       4
`define UART_LC_DLAB      7

`define UART_MC_DTR       0
`define UART_MC_RTS       1
`define UART_MC_OUT1      2
`define UART_MC_OUT2      3
`define UART_MC_LOOP      4

`define UART_IE_THRE      1
`define UART_IE_MS        3

`define UART_LS_THRE      5
`define UART_LS_TEMT      6

`endif

/* sim/tb_uart.sv */
`timescale 1ns/1ps
`include "uart_defs.svh"

module tb_uart
    import uart_pkg::*;
;

    localparam int N_FRAMES   = 20 + 16 + 2;
    localparam int TIMEOUT_NS = (N_FRAMES * 12 * `UART_OVERSAMPLE * 3 + 4000) * 40;

    logic                    clk = 1'b0;
    logic                    wb_rst_i = 1'b1;
    logic [`UART_ADDR_W-1:0] wb_addr_i = '0;
    logic [`UART_DATA_W-1:0] wb_dat_i = '0;
    logic [`UART_DATA_W-1:0] wb_dat_o;
    logic                    wb_we_i = 1'b0;
    logic                    wb_re_i = 1'b0;
    logic [3:0]              modem_inputs_i = 4'hF;
    logic                    stx_pad_o;
    logic                    rts_pad_o;
    logic                    dtr_pad_o;
    logic                    int_o;
    logic [31:0]             lfsr = 32'h5ee6_5264;
    int                      errors = 0;
    int                      sent = 0;

    uart_top UUT (.*);

    uart_checker frame_chk (
        .clk       (clk),
        .wb_rst_i  (wb_rst_i),
        .stx_i     (stx_pad_o),
        .wb_addr_i (wb_addr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_we_i   (wb_we_i)
    );

    always #20 clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        logic       fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[6:0], fb};
        end
        return r;
    endfunction

    // start, data lsb first, optional parity, one or two stops
    function automatic logic [11:0] expected_frame(input logic [7:0] data,
                                                   input logic [7:0] lcr, output int len);
        logic [11:0] bits;
        int          nbits;
        int          idx;
        logic        par;
        bits    = '1;
        nbits   = lcr[1:0] + 5;
        bits[0] = 1'b0;
        par     = 1'b0;
        for (int i = 0; i < nbits; i++)
        begin
            bits[1 + i] = data[i];
            par         = par ^ data[i];
        end
        idx = 1 + nbits;
        if (lcr[`UART_LC_PEN])
        begin
            bits[idx] = lcr[`UART_LC_EPS] ? par : ~par;  // even parity keeps the ones even
            idx++;
        end
        idx = idx + (lcr[`UART_LC_STB] ? 2 : 1);
        len = idx;
        return bits;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic bus_write(input logic [2:0] addr, input logic [7:0] data);
        @(negedge clk);
        wb_addr_i = addr;
        wb_dat_i  = data;
        wb_we_i   = 1'b1;
        @(negedge clk);
        wb_we_i = 1'b0;
    endtask

    task automatic bus_read(input logic [2:0] addr, output logic [7:0] data);
        @(negedge clk);
        wb_addr_i = addr;
        wb_re_i   = 1'b1;
        #5 data = wb_dat_o;
        @(negedge clk);
        wb_re_i = 1'b0;
    endtask

    task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act)
        begin
            $display("FAILED at %0t: %s expected %02h got %02h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input logic [2:0] addr, input logic [7:0] exp);
        logic [7:0] d;
        bus_read(addr, d);
        check_val(name, exp, d);
    endtask

    task automatic send_byte(input logic [7:0] data, input logic [7:0] lcr);
        logic [11:0] bits;
        int          len;
        bits = expected_frame(data, lcr, len);
        frame_chk.add_expected(bits, len, lcr[1:0] + 5, data);
        bus_write(REG_TR, data);
        sent++;
    endtask

    task automatic wait_temt();
        logic [7:0] d;
        int         polls;
        idle(4);  // lsr lags the push
        polls = 0;
        d     = 8'h00;
        while (!d[`UART_LS_TEMT] && polls < 2000)
        begin
            bus_read(REG_LS, d);
            polls++;
        end
        if (!d[`UART_LS_TEMT])
        begin
            $display("TEMT never set in the line status register at %0t", $time);
            errors++;
        end
    endtask

    task automatic wait_int(input logic level);
        int n;
        n = 0;
        while (int_o !== level && n < 100)
        begin
            @(negedge clk);
            n++;
        end
        if (int_o !== level)
        begin
            $display("int_o did not go to %0b at %0t", level, $time);
            errors++;
        end
    endtask

    task automatic set_divisor(input logic [15:0] dl, input logic [7:0] lcr);
        bus_write(REG_LC, lcr | 8'h80);
        bus_write(REG_IE, dl[15:8]);
        bus_write(REG_TR, dl[7:0]);  // low latch write reloads the baud counter
        bus_write(REG_LC, lcr);
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("Watchdog timeout, the run did not finish in %0d ns", TIMEOUT_NS);
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        logic [7:0] lcr;
        logic [7:0] d;
        logic [7:0] pins;
        repeat (4) @(posedge clk);
        @(negedge clk);
        wb_rst_i = 1'b0;

        // reset values and readback
        check_reg("lcr reset", REG_LC, 8'h03);
        check_reg("iir reset", REG_II, 8'hC1);
        check_reg("lsr reset", REG_LS, 8'h60);
        bus_write(REG_LC, 8'h7A);
        check_reg("lcr", REG_LC, 8'h7A);
        bus_write(REG_IE, 8'hF5);
        check_reg("ier", REG_IE, 8'h05);
        bus_write(REG_IE, 8'h00);
        bus_write(REG_MC, 8'hFF);
        check_reg("mcr", REG_MC, 8'h1F);
        bus_write(REG_MC, 8'h00);
        bus_write(REG_LC, 8'h83);
        bus_write(REG_TR, 8'hA5);
        bus_write(REG_IE, 8'h3C);
        check_reg("dll", REG_TR, 8'hA5);
        check_reg("dlm", REG_IE, 8'h3C);
        set_divisor(16'd1, 8'h03);

        // random frame formats at dl 1
        for (int i = 0; i < 20; i++)
        begin
            lcr = {3'b000, rand_bits(5)};
            bus_write(REG_LC, lcr);
            send_byte(rand_bits(8), lcr);
            wait_temt();
        end

        // fifo order at 8n1
        bus_write(REG_LC, 8'h03);
        for (int i = 0; i < 16; i++)
            send_byte(rand_bits(8), 8'h03);
        idle(4);
        bus_read(REG_LS, d);
        check_val("lsr thre", 8'h00, d & 8'h20);
        wait_temt();
        bus_read(REG_LS, d);
        check_val("lsr thre", 8'h20, d & 8'h20);

        // divisor 3
        set_divisor(16'd3, 8'h07);
        send_byte(rand_bits(8), 8'h07);
        send_byte(rand_bits(8), 8'h07);
        wait_temt();

        // modem pins and loopback
        bus_write(REG_MC, 8'h03);
        idle(1);
        check_val("rts_pad_o", 8'h01, {7'd0, rts_pad_o});
        check_val("dtr_pad_o", 8'h01, {7'd0, dtr_pad_o});
        bus_write(REG_MC, 8'h01);
        idle(1);
        check_val("rts_pad_o", 8'h00, {7'd0, rts_pad_o});
        check_val("dtr_pad_o", 8'h01, {7'd0, dtr_pad_o});
        bus_write(REG_MC, 8'h10);
        idle(3);
        bus_read(REG_MS, d);
        idle(3);
        bus_write(REG_MC, 8'h1A);  // loop with out2 and rts
        idle(3);
        check_reg("msr loop", REG_MS, 8'h99);
        idle(3);
        check_reg("msr cleared", REG_MS, 8'h90);
        bus_write(REG_MC, 8'h00);
        idle(3);
        bus_read(REG_MS, d);
        @(negedge clk);
        modem_inputs_i = 4'b1010;
        idle(3);
        pins = {~modem_inputs_i[0], ~modem_inputs_i[1], ~modem_inputs_i[2], ~modem_inputs_i[3],
                4'h0};
        bus_read(REG_MS, d);
        check_val("msr pins", pins, d & 8'hF0);
        @(negedge clk);
        modem_inputs_i = 4'hF;
        idle(3);
        bus_read(REG_MS, d);
        idle(3);

        // interrupts
        bus_write(REG_IE, 8'h02);
        wait_int(1'b1);
        check_reg("iir thre", REG_II, 8'hC2);
        idle(4);
        bus_write(REG_IE, 8'h0A);
        @(negedge clk);
        modem_inputs_i = 4'hE;
        wait_int(1'b1);
        idle(2);
        check_reg("iir ms", REG_II, 8'hC0);
        bus_read(REG_MS, d);
        wait_int(1'b0);
        idle(2);
        check_reg("iir none", REG_II, 8'hC1);

        idle(20);
        if (frame_chk.frames != sent)
        begin
            $display("Only %0d of %0d frames were seen on the line", frame_chk.frames, sent);
            errors++;
        end
        $display("Errors: bus %0d, line %0d, frames checked %0d",
                 errors, frame_chk.errors, frame_chk.frames);
        if (errors == 0 && frame_chk.errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* sim/uart_checker.sv */
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_checker
    import uart_pkg::*;
(
    input logic                    clk,
    input logic                    wb_rst_i,
    input logic                    stx_i,
    input logic [`UART_ADDR_W-1:0] wb_addr_i,
    input logic [`UART_DATA_W-1:0] wb_dat_i,
    input logic                    wb_we_i
);

    logic [11:0] exp_bits_q [$];
    int          exp_len_q [$];
    int          exp_nbits_q [$];
    logic [7:0]  exp_data_q [$];
    int          errors = 0;
    int          frames = 0;
    logic        dlab;
    logic [15:0] dl;

    task automatic add_expected(input logic [11:0] bits, input int len, input int nbits,
                                input logic [7:0] data);
        exp_bits_q.push_back(bits);
        exp_len_q.push_back(len);
        exp_nbits_q.push_back(nbits);
        exp_data_q.push_back(data);
    endtask

    // snoop the bus for the divisor so the bit period is known
    always @(posedge clk or posedge wb_rst_i)
    begin
        if (wb_rst_i)
        begin
            dlab <= 1'b0;
            dl   <= '0;
        end
        else if (wb_we_i)
        begin
            if (wb_addr_i == REG_LC)
                dlab <= wb_dat_i[`UART_LC_DLAB];
            else if (dlab && wb_addr_i == REG_TR)
                dl[7:0] <= wb_dat_i;
            else if (dlab && wb_addr_i == REG_IE)
                dl[15:8] <= wb_dat_i;
        end
    end

    initial
    begin
        logic [11:0] got;
        logic [11:0] exp_bits;
        logic [7:0]  exp_data;
        logic [7:0]  got_data;
        logic [7:0]  mask;
        int          len;
        int          nbits;
        int          bit_clks;
        forever
        begin
            @(negedge stx_i);
            if (!wb_rst_i)
            begin
                if (exp_bits_q.size() == 0)
                begin
                    $display("Frame started on the serial line with nothing expected at %0t", $time);
                    errors++;
                    continue;
                end
                exp_bits = exp_bits_q.pop_front();
                len      = exp_len_q.pop_front();
                nbits    = exp_nbits_q.pop_front();
                exp_data = exp_data_q.pop_front();
                bit_clks = `UART_OVERSAMPLE * dl;
                got      = '1;
                repeat (bit_clks / 2) @(negedge clk);  // middle of start bit
                got[0] = stx_i;
                for (int i = 1; i < len; i++)
                begin
                    repeat (bit_clks) @(negedge clk);
                    got[i] = stx_i;
                end
                mask     = 8'hFF >> (8 - nbits);
                got_data = 8'h00;
                for (int i = 0; i < nbits; i++)
                    got_data[i] = got[1 + i];
                if (got != exp_bits)
                begin
                    $display("FAILED at %0t: stx_pad_o frame expected %03h got %03h",
                             $time, exp_bits, got);
                    errors++;
                end
                if ((got_data & mask) != (exp_data & mask))
                begin
                    $display("FAILED at %0t: tx data expected %02h got %02h",
                             $time, exp_data & mask, got_data & mask);
                    errors++;
                end
                frames++;
            end
        end
    end

endmodule

/* tb.f */
+incdir+include
verilog/uart_pkg.sv
verilog/uart_regs.sv
verilog/uart_tx_fifo.sv
verilog/uart_transmitter.sv
verilog/uart_modem_int.sv
verilog/uart_top.sv
sim/uart_checker.sv
sim/tb_uart.sv

/* verilog/uart_modem_int.sv */
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_modem_int
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       wb_rst_i,
    input  logic [3:0] modem_inputs_i,
    input  logic [4:0] mcr_i,
    input  logic [3:0] ier_i,
    input  logic       msr_rd_i,
    input  logic       iir_rd_i,
    input  logic       tf_push_i,
    input  logic       fifo_empty_i,
    output logic [7:0] msr_o,
    output logic [3:0] iir_o,
    output logic       int_o
);

    logic       cts;
    logic       dsr;
    logic       ri;
    logic       dcd;
    logic [3:0] modem_now;
    logic       thre_clear;
    logic       thre_int;
    logic       ms_int;

    // loopback ties the modem status back to mcr
    assign {cts, dsr, ri, dcd} = mcr_i[`UART_MC_LOOP] ?
        {mcr_i[`UART_MC_RTS], mcr_i[`UART_MC_DTR], mcr_i[`UART_MC_OUT1], mcr_i[`UART_MC_OUT2]} :
        ~modem_inputs_i;
    assign modem_now = {dcd, ri, dsr, cts};

    always_ff @(posedge clk or posedge wb_rst_i)
    begin
        if (wb_rst_i)
            msr_o <= '0;
        else
        begin
            msr_o[7:4] <= modem_now;
            msr_o[3:0] <= msr_rd_i ? 4'b0000 : msr_o[3:0] | (modem_now ^ msr_o[7:4]);
        end
    end

    always_ff @(posedge clk or posedge wb_rst_i)
    begin
        if (wb_rst_i)
            thre_clear <= 1'b0;
        else if (tf_push_i)
            thre_clear <= 1'b0;  // new byte re-arms thre
        else if (iir_rd_i)
            thre_clear <= 1'b1;
    end

    always_ff @(posedge clk or posedge wb_rst_i)
    begin
        if (wb_rst_i)
        begin
            thre_int <= 1'b0;
            ms_int   <= 1'b0;
            int_o    <= 1'b0;
        end
        else
        begin
            thre_int <= ier_i[`UART_IE_THRE] && fifo_empty_i && !thre_clear;
            ms_int   <= ier_i[`UART_IE_MS] && (|msr_o[3:0]);
            int_o    <= thre_int || ms_int;
        end
    end

    // thre ranks above modem status
    always_ff @(posedge clk or posedge wb_rst_i)
    begin
        if (wb_rst_i)
            iir_o <= `UART_IIR_RESET;
        else if (thre_int)
            iir_o <= {INT_THRE, 1'b0};
        else if (ms_int)
            iir_o <= {INT_MS, 1'b0};
        else
            iir_o <= `UART_IIR_RESET;
    end

endmodule

/* verilog/uart_pkg.sv */
`include "uart_defs.svh"

package uart_pkg;

    // divisor latch lsb/msb sit on 0 and 1 while dlab is set
    typedef enum logic [`UART_ADDR_W-1:0] {
        REG_TR = 0,
        REG_IE = 1,
        REG_II = 2,
        REG_LC = 3,
        REG_MC = 4,
        REG_LS = 5,
        REG_MS = 6
    } uart_reg_e;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_e;

    // iir[3:1] codes
    typedef enum logic [2:0] {
        INT_MS   = 3'b000,
        INT_THRE = 3'b001
    } int_id_e;

endpackage

/* verilog/uart_regs.sv */
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_regs
    import uart_pkg::*;
(
    input  logic                    clk,
    input  logic                    wb_rst_i,
    input  logic [`UART_ADDR_W-1:0] wb_addr_i,
    input  logic [`UART_DATA_W-1:0] wb_dat_i,
    output logic [`UART_DATA_W-1:0] wb_dat_o,
    input  logic                    wb_we_i,
    input  logic                    wb_re_i,
    output logic                    tf_push_o,
    output logic [`UART_DATA_W-1:0] tf_data_o,
    input  logic                    fifo_empty_i,
    input  logic                    tx_idle_i,
    input  logic [7:0]              msr_i,
    input  logic [3:0]              iir_i,
    output logic                    baud_en_o,
    output logic [7:0]              lcr_o,
    output logic [4:0]              mcr_o,
    output logic [3:0]              ier_o,
    output logic                    msr_rd_o,
    output logic                    iir_rd_o,
    output logic                    rts_pad_o,
    output logic                    dtr_pad_o
);

    uart_reg_e             reg_addr;
    logic                  dlab;
    logic                  wr_thr;
    logic [`UART_DL_W-1:0] dl;
    logic [`UART_DL_W-1:0] dlc;
    logic                  start_dlc;
    logic [7:0]            lsr;

    assign reg_addr  = uart_reg_e'(wb_addr_i);
    assign dlab      = lcr_o[`UART_LC_DLAB];
    assign wr_thr    = wb_we_i && (reg_addr == REG_TR) && !dlab;
    assign rts_pad_o = mcr_o[`UART_MC_RTS];
    assign dtr_pad_o = mcr_o[`UART_MC_DTR];

    always_comb
    begin
        case (reg_addr)
            REG_TR:  wb_dat_o = dlab ? dl[`UART_DATA_W-1:0] : '0;  // no receiver behind rb
            REG_IE:  wb_dat_o = dlab ? dl[`UART_DL_W-1:`UART_DATA_W] : {4'b0000, ier_o};
            REG_II:  wb_dat_o = {4'b1100, iir_i};
            REG_LC:  wb_dat_o = lcr_o;
            REG_MC:  wb_dat_o = {3'b000, mcr_o};
            REG_LS:  wb_dat_o = lsr;
            REG_MS:  wb_dat_o = msr_i;
            default: wb_dat_o = '0;
        endcase
    end

    always_ff @(posedge clk or posedge wb_rst_i)
    begin
        if (wb_rst_i)
        begin
            lcr_o     <= `UART_LCR_RESET;
            ier_o     <= '0;
            mcr_o     <= '0;
            dl        <= '0;
            tf_push_o <= 1'b0;
            start_dlc <= 1'b0;
        end
        else
        begin
            tf_push_o <= wr_thr;
            start_dlc <= 1'b0;
            if (wb_we_i)
            begin
                case (reg_addr)
                    REG_TR:
                        if (dlab)
                        begin
                            dl[`UART_DATA_W-1:0] <= wb_dat_i;
                            start_dlc            <= 1'b1;  // restart baud count
                        end
                    REG_IE:
                        if (dlab)
                            dl[`UART_DL_W-1:`UART_DATA_W] <= wb_dat_i;
                        else
                            ier_o <= wb_dat_i[3:0];
                    REG_LC:  lcr_o <= wb_dat_i;
                    REG_MC:  mcr_o <= wb_dat_i[4:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_thr)
            tf_data_o <= wb_dat_i;
    end

    always_ff @(posedge clk or posedge wb_rst_i)
    begin
        if (wb_rst_i)
        begin
            msr_rd_o <= 1'b0;
            iir_rd_o <= 1'b0;
        end
        else
        begin
            msr_rd_o <= wb_re_i && (reg_addr == REG_MS);
            iir_rd_o <= wb_re_i && (reg_addr == REG_II);
        end
    end

    // one baud enable pulse every dl clocks
    always_ff @(posedge clk or posedge wb_rst_i)
    begin
        if (wb_rst_i)
        begin
            dlc       <= '0;
            baud_en_o <= 1'b0;
        end
        else if (start_dlc)
        begin
            dlc       <= dl;
            baud_en_o <= 1'b0;
        end
        else if (dl == '0)
        begin
            dlc       <= '0;
            baud_en_o <= 1'b0;
        end
        else if (dlc < 2)
        begin
            dlc       <= dl;  // reload on expiry
            baud_en_o <= 1'b1;
        end
        else
        begin
            dlc       <= dlc - 1'b1;
            baud_en_o <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge wb_rst_i)
    begin
        if (wb_rst_i)
            lsr <= `UART_LSR_RESET;
        else
        begin
            lsr                <= '0;
            lsr[`UART_LS_THRE] <= fifo_empty_i;
            lsr[`UART_LS_TEMT] <= fifo_empty_i && tx_idle_i;
        end
    end

endmodule

/* verilog/uart_top.sv */
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_top (
    input  logic                    clk,
    input  logic                    wb_rst_i,
    input  logic [`UART_ADDR_W-1:0] wb_addr_i,
    input  logic [`UART_DATA_W-1:0] wb_dat_i,
    output logic [`UART_DATA_W-1:0] wb_dat_o,
    input  logic                    wb_we_i,
    input  logic                    wb_re_i,
    input  logic [3:0]              modem_inputs_i,  // cts, dsr, ri, dcd
    output logic                    stx_pad_o,
    output logic                    rts_pad_o,
    output logic                    dtr_pad_o,
    output logic                    int_o
);

    logic                    tf_push;
    logic [`UART_DATA_W-1:0] tf_data;
    logic                    tf_pop;
    logic                    fifo_empty;
    logic [`UART_DATA_W-1:0] fifo_data;
    logic                    tx_idle;
    logic                    baud_en;
    logic [7:0]              lcr;
    logic [4:0]              mcr;
    logic [3:0]              ier;
    logic [7:0]              msr;
    logic [3:0]              iir;
    logic                    msr_rd;
    logic                    iir_rd;

    uart_regs regs (
        .clk          (clk),
        .wb_rst_i     (wb_rst_i),
        .wb_addr_i    (wb_addr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_we_i      (wb_we_i),
        .wb_re_i      (wb_re_i),
        .tf_push_o    (tf_push),
        .tf_data_o    (tf_data),
        .fifo_empty_i (fifo_empty),
        .tx_idle_i    (tx_idle),
        .msr_i        (msr),
        .iir_i        (iir),
        .baud_en_o    (baud_en),
        .lcr_o        (lcr),
        .mcr_o        (mcr),
        .ier_o        (ier),
        .msr_rd_o     (msr_rd),
        .iir_rd_o     (iir_rd),
        .rts_pad_o    (rts_pad_o),
        .dtr_pad_o    (dtr_pad_o)
    );

    uart_tx_fifo tx_fifo (
        .clk      (clk),
        .wb_rst_i (wb_rst_i),
        .push_i   (tf_push),
        .data_i   (tf_data),
        .pop_i    (tf_pop),
        .data_o   (fifo_data),
        .empty_o  (fifo_empty)
    );

    uart_transmitter transmitter (
        .clk          (clk),
        .wb_rst_i     (wb_rst_i),
        .baud_en_i    (baud_en),
        .lcr_i        (lcr),
        .fifo_empty_i (fifo_empty),
        .fifo_data_i  (fifo_data),
        .pop_o        (tf_pop),
        .tx_idle_o    (tx_idle),
        .stx_pad_o    (stx_pad_o)
    );

    uart_modem_int modem_int (
        .clk            (clk),
        .wb_rst_i       (wb_rst_i),
        .modem_inputs_i (modem_inputs_i),
        .mcr_i          (mcr),
        .ier_i          (ier),
        .msr_rd_i       (msr_rd),
        .iir_rd_i       (iir_rd),
        .tf_push_i      (tf_push),
        .fifo_empty_i   (fifo_empty),
        .msr_o          (msr),
        .iir_o          (iir),
        .int_o          (int_o)
    );

endmodule

/* verilog/uart_transmitter.sv */
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_transmitter
    import uart_pkg::*;
(
    input  logic                    clk,
    input  logic                    wb_rst_i,
    input  logic                    baud_en_i,
    input  logic [7:0]              lcr_i,
    input  logic                    fifo_empty_i,
    input  logic [`UART_DATA_W-1:0] fifo_data_i,
    output logic                    pop_o,
    output logic                    tx_idle_o,
    output logic                    stx_pad_o
);

    localparam int TICK_W = $clog2(`UART_OVERSAMPLE);

    tx_state_e               state;
    logic [TICK_W-1:0]       tick_cnt;
    logic                    bit_done;
    logic [2:0]              bit_idx;
    logic [2:0]              last_bit;
    logic [`UART_DATA_W-1:0] word_mask;
    logic [`UART_DATA_W-1:0] shreg;
    logic                    parity_bit;
    logic                    second_stop;

    assign bit_done  = baud_en_i && (tick_cnt == TICK_W'(`UART_OVERSAMPLE - 1));
    assign last_bit  = {1'b0, lcr_i[1:0]} + 3'd4;  // 5..8 data bits
    assign word_mask = 8'hFF >> (2'd3 - lcr_i[1:0]);
    assign pop_o     = (state == TX_IDLE) && baud_en_i && !fifo_empty_i;
    assign tx_idle_o = (state == TX_IDLE);

    always_ff @(posedge clk or posedge wb_rst_i)
    begin
        if (wb_rst_i)
        begin
            state       <= TX_IDLE;
            tick_cnt    <= '0;
            bit_idx     <= '0;
            second_stop <= 1'b0;
        end
        else
        begin
            if (state == TX_IDLE)
                tick_cnt <= '0;
            else if (baud_en_i)
                tick_cnt <= tick_cnt + 1'b1;
            case (state)
                TX_IDLE:
                    if (pop_o)
                        state <= TX_START;
                TX_START:
                    if (bit_done)
                    begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                    end
                TX_DATA:
                    if (bit_done)
                    begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == last_bit)
                        begin
                            state       <= lcr_i[`UART_LC_PEN] ? TX_PARITY : TX_STOP;
                            second_stop <= 1'b0;
                        end
                    end
                TX_PARITY:
                    if (bit_done)
                    begin
                        state       <= TX_STOP;
                        second_stop <= 1'b0;
                    end
                TX_STOP:
                    if (bit_done)
                    begin
                        if (lcr_i[`UART_LC_STB] && !second_stop)
                            second_stop <= 1'b1;
                        else
                            state <= TX_IDLE;
                    end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // byte and its parity latched with the pop
    always_ff @(posedge clk)
    begin
        if (pop_o)
        begin
            shreg      <= fifo_data_i;
            parity_bit <= (^(fifo_data_i & word_mask)) ~^ lcr_i[`UART_LC_EPS];
        end
        else if ((state == TX_DATA) && bit_done)
            shreg <= shreg >> 1;
    end

    always_ff @(posedge clk or posedge wb_rst_i)
    begin
        if (wb_rst_i)
            stx_pad_o <= 1'b1;
        else
        begin
            case (state)
                TX_START:  stx_pad_o <= 1'b0;
                TX_DATA:   stx_pad_o <= shreg[0];  // lsb first
                TX_PARITY: stx_pad_o <= parity_bit;
                default:   stx_pad_o <= 1'b1;
            endcase
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (wb_rst_i)
        (state == TX_IDLE) |-> stx_pad_o);

endmodule

/* verilog/uart_tx_fifo.sv */
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_tx_fifo (
    input  logic                    clk,
    input  logic                    wb_rst_i,
    input  logic                    push_i,
    input  logic [`UART_DATA_W-1:0] data_i,
    input  logic                    pop_i,
    output logic [`UART_DATA_W-1:0] data_o,
    output logic                    empty_o
);

    localparam int PTR_W = $clog2(`UART_FIFO_DEPTH);

    logic [`UART_DATA_W-1:0]     mem [`UART_FIFO_DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [`UART_FIFO_CNT_W-1:0] count;
    logic                        full;
    logic                        push_ok;
    logic                        pop_ok;

    assign full    = (count == `UART_FIFO_DEPTH);
    assign empty_o = (count == '0);
    assign push_ok = push_i && !full;  // push into full fifo is lost
    assign pop_ok  = pop_i && !empty_o;
    assign data_o  = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push_ok)
            mem[wr_ptr] <= data_i;
    end

    always_ff @(posedge clk or posedge wb_rst_i)
    begin
        if (wb_rst_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // host must poll thre before writing
    a_no_push_full: assert property (@(posedge clk) disable iff (wb_rst_i) push_i |-> !full);

    a_no_pop_empty: assert property (@(posedge clk) disable iff (wb_rst_i) pop_i |-> !empty_o);

endmodule
